/* all.f */
hdl/rv_isa_pkg.sv
hdl/exu_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/lsu.sv
hdl/exu_ctrl.sv
hdl/exu_top.sv
test/clk_gen.sv
test/tb_exu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_exu
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint clean

all:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "sim passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* test/tb_exu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exu;
    typedef struct {
        rv_isa_pkg::opcode_t  op;
        rv_isa_pkg::funct3_t  f3;
        logic                 alt;
        rv_isa_pkg::xlen_t    s1, s2, imm, pc;
        rv_isa_pkg::reg_idx_t rd;
        rv_isa_pkg::xlen_t    exp_data;
        logic                 exp_wen, exp_redir;
        rv_isa_pkg::xlen_t    exp_pc;
    } entry_t;

    wire  clk;
    logic rst_n, issue_valid, alt, out_credit;
    rv_isa_pkg::opcode_t  op;
    rv_isa_pkg::funct3_t  funct3;
    rv_isa_pkg::xlen_t    src1, src2, imm, pc, res_data, redirect_pc;
    rv_isa_pkg::reg_idx_t rd, res_rd;
    logic in_credit, res_valid, res_wen, redirect_valid;

    entry_t tbl[$];
    logic [7:0] mem_model [256];
    int seed = 27;
    int sent = 0, chk = 0, icnt, out_cnt, owed = 0, res_seen = 0, hold_left = 15;
    int gap = 0, cycles = 0, limit = 100;
    logic stalled = 1'b0;

    clk_gen u_clk (.clk(clk));

    exu_top UUT (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .op(op), .funct3(funct3),
        .alt(alt), .src1(src1), .src2(src2), .imm(imm), .pc(pc), .rd(rd),
        .in_credit(in_credit), .res_valid(res_valid), .res_rd(res_rd), .res_wen(res_wen),
        .res_data(res_data), .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
        .out_credit(out_credit)
    );

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input rv_isa_pkg::xlen_t got,
                              input rv_isa_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_target(input string name, input rv_isa_pkg::xlen_t got,
                                input rv_isa_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_entry(input rv_isa_pkg::opcode_t o, input rv_isa_pkg::funct3_t f,
                             input logic a, input rv_isa_pkg::xlen_t x, input rv_isa_pkg::xlen_t y,
                             input rv_isa_pkg::xlen_t i, input rv_isa_pkg::xlen_t p,
                             input rv_isa_pkg::xlen_t d, input logic w, input logic r,
                             input rv_isa_pkg::xlen_t t);
        entry_t e;
        e = '{o, f, a, x, y, i, p, rv_isa_pkg::reg_idx_t'(tbl.size()), d, w, r, t};
        tbl.push_back(e);
    endtask

    // stores update the byte model as they enter the table
    task automatic add_store(input rv_isa_pkg::funct3_t f, input logic [7:0] addr,
                             input rv_isa_pkg::xlen_t d);
        int n;
        n = (f == rv_isa_pkg::F3_SB) ? 1 : (f == rv_isa_pkg::F3_SH) ? 2 : 4;
        for (int i = 0; i < n; i++)
            mem_model[addr + 8'(i)] = d[8*i +: 8];
        add_entry(rv_isa_pkg::OPC_STORE, f, 1'b0, 32'(addr) - 32'd4, d, 32'd4, 32'd0,
                  32'd0, 1'b0, 1'b0, 32'd0);
    endtask

    task automatic add_load(input rv_isa_pkg::funct3_t f, input logic [7:0] addr);
        rv_isa_pkg::xlen_t w, v;
        logic [7:0] base;
        base = {addr[7:2], 2'b00};
        w = {mem_model[base + 8'd3], mem_model[base + 8'd2], mem_model[base + 8'd1],
             mem_model[base]};
        w = w >> (8 * addr[1:0]);
        case (f)
            rv_isa_pkg::F3_LB:  v = {{24{w[7]}}, w[7:0]};
            rv_isa_pkg::F3_LH:  v = {{16{w[15]}}, w[15:0]};
            rv_isa_pkg::F3_LBU: v = {24'b0, w[7:0]};
            rv_isa_pkg::F3_LHU: v = {16'b0, w[15:0]};
            default:            v = w;
        endcase
        add_entry(rv_isa_pkg::OPC_LOAD, f, 1'b0, 32'(addr) + 32'd8, 32'd0, 32'hFFFF_FFF8,
                  32'd0, v, 1'b1, 1'b0, 32'd0);
    endtask

    task automatic add_branch(input rv_isa_pkg::funct3_t f, input rv_isa_pkg::xlen_t x,
                              input rv_isa_pkg::xlen_t y, input logic taken);
        add_entry(rv_isa_pkg::OPC_BRANCH, f, 1'b0, x, y, 32'hFFFF_FFE0, 32'h100, 32'd0,
                  1'b0, taken, 32'h0E0);   // 0x100 - 0x20
    endtask

    task automatic build_table();
        add_entry(rv_isa_pkg::OPC_OP, 3'b000, 0, 5, 7, 0, 0, 12, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b000, 1, 5, 7, 0, 0, 32'hFFFF_FFFE, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b010, 0, 32'hFFFF_FFFF, 1, 0, 0, 1, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b011, 0, 32'hFFFF_FFFF, 1, 0, 0, 0, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b100, 0, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 0, 0,
                  32'hFF00_FF00, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b110, 0, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 0, 0,
                  32'hFFF0_FFF0, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b111, 0, 32'hF0F0_F0F0, 32'h0FF0_0FF0, 0, 0,
                  32'h00F0_00F0, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b001, 0, 3, 31, 0, 0, 32'h8000_0000, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b101, 0, 32'h8000_0000, 31, 0, 0, 1, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP, 3'b101, 1, 32'h8000_0000, 31, 0, 0, 32'hFFFF_FFFF,
                  1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP_IMM, 3'b000, 0, 10, 0, 32'hFFFF_FFFD, 0, 7, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP_IMM, 3'b010, 0, 32'hFFFF_FFF0, 0, 5, 0, 1, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_OP_IMM, 3'b101, 1, 32'h8000_0000, 0, 31, 0,
                  32'hFFFF_FFFF, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_LUI, 3'b000, 0, 32'h5555_5555, 0, 32'h1234_5000, 0,
                  32'h1234_5000, 1, 0, 0);
        add_entry(rv_isa_pkg::OPC_AUIPC, 3'b000, 0, 0, 0, 32'h2000, 32'h1000, 32'h3000,
                  1, 0, 0);
        add_store(rv_isa_pkg::F3_SW, 8'h40, 32'h1122_3344);
        add_store(rv_isa_pkg::F3_SW, 8'h44, 32'hAABB_CCDD);
        add_store(rv_isa_pkg::F3_SH, 8'h46, 32'h0000_8765);
        add_store(rv_isa_pkg::F3_SW, 8'h48, 32'h0000_0000);
        add_store(rv_isa_pkg::F3_SB, 8'h49, 32'h0000_00F0);
        add_load(rv_isa_pkg::F3_LW, 8'h40);
        add_load(rv_isa_pkg::F3_LH, 8'h46);
        add_load(rv_isa_pkg::F3_LHU, 8'h46);
        add_load(rv_isa_pkg::F3_LB, 8'h49);
        add_load(rv_isa_pkg::F3_LBU, 8'h49);
        add_load(rv_isa_pkg::F3_LB, 8'h44);
        add_load(rv_isa_pkg::F3_LW, 8'h44);
        add_branch(rv_isa_pkg::F3_BEQ, 5, 5, 1);
        add_branch(rv_isa_pkg::F3_BEQ, 5, 6, 0);
        add_branch(rv_isa_pkg::F3_BNE, 5, 6, 1);
        add_branch(rv_isa_pkg::F3_BNE, 5, 5, 0);
        add_branch(rv_isa_pkg::F3_BLT, 32'hFFFF_FFFF, 1, 1);
        add_branch(rv_isa_pkg::F3_BLT, 1, 32'hFFFF_FFFF, 0);
        add_branch(rv_isa_pkg::F3_BGE, 1, 32'hFFFF_FFFF, 1);
        add_branch(rv_isa_pkg::F3_BGE, 32'hFFFF_FFFF, 1, 0);
        add_branch(rv_isa_pkg::F3_BLTU, 1, 32'hFFFF_FFFF, 1);
        add_branch(rv_isa_pkg::F3_BLTU, 32'hFFFF_FFFF, 1, 0);
        add_branch(rv_isa_pkg::F3_BGEU, 32'hFFFF_FFFF, 1, 1);
        add_branch(rv_isa_pkg::F3_BGEU, 1, 32'hFFFF_FFFF, 0);
        add_entry(rv_isa_pkg::OPC_JAL, 3'b000, 0, 0, 0, 32'h80, 32'h200, 32'h204, 1, 1,
                  32'h280);
        add_entry(rv_isa_pkg::OPC_JALR, 3'b000, 0, 32'h1001, 0, 32'h10, 32'h300, 32'h304,
                  1, 1, 32'h1010);   // bit 0 cleared
    endtask

    // issuer with credit count
    always @(posedge clk) begin
        if (rst_n) begin
            icnt = icnt + int'(in_credit);
            if (icnt > int'(exu_pkg::EXU_SLOTS)) begin
                $display("issuer received more credits than pipeline slots");
                abort_run();
            end
            #1;
            issue_valid = 1'b0;
            if (gap > 0) begin
                gap = gap - 1;
            end else if (icnt > 0 && sent < tbl.size()) begin
                op = tbl[sent].op;
                funct3 = tbl[sent].f3;
                alt = tbl[sent].alt;
                src1 = tbl[sent].s1;
                src2 = tbl[sent].s2;
                imm = tbl[sent].imm;
                pc = tbl[sent].pc;
                rd = tbl[sent].rd;
                issue_valid = 1'b1;
                icnt = icnt - 1;
                sent = sent + 1;
                gap = $unsigned($random(seed)) % 3;
            end
        end
    end

    // result checker
    always @(posedge clk) begin
        if (rst_n && res_valid) begin
            if (chk >= tbl.size()) begin
                $display("result arrived with no instruction outstanding");
                abort_run();
            end
            check_bit("in_credit", in_credit, 1'b1);
            check_data("res_rd", rv_isa_pkg::xlen_t'(res_rd), rv_isa_pkg::xlen_t'(tbl[chk].rd));
            check_bit("res_wen", res_wen, tbl[chk].exp_wen);
            if (tbl[chk].exp_wen)
                check_data("res_data", res_data, tbl[chk].exp_data);
            check_bit("redirect_valid", redirect_valid, tbl[chk].exp_redir);
            if (tbl[chk].exp_redir || tbl[chk].op == rv_isa_pkg::OPC_BRANCH)
                check_target("redirect_pc", redirect_pc, tbl[chk].exp_pc);
            chk = chk + 1;
        end else if (rst_n) begin
            check_bit("in_credit", in_credit, 1'b0);
        end
    end

    // write-back buffer that holds its credits for a while after result 6
    always @(posedge clk) begin
        if (rst_n) begin
            if (res_valid && out_cnt == 0) begin
                $display("result presented while no output credit was left");
                abort_run();
            end
            out_cnt = out_cnt - int'(res_valid) + int'(out_credit);
            if (out_cnt == 0)
                stalled = 1'b1;
            owed = owed + int'(res_valid);
            res_seen = res_seen + int'(res_valid);
            if (res_seen >= 6 && hold_left > 0)
                hold_left = hold_left - 1;
            #1;
            out_credit = 1'b0;
            if (!(res_seen >= 6 && hold_left > 0) && owed > 0) begin
                out_credit = 1'b1;
                owed = owed - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, results stopped arriving", cycles);
            abort_run();
        end
    end

    initial begin
        rst_n = 1'b0;
        issue_valid = 1'b0;
        op = '0;
        funct3 = '0;
        alt = 1'b0;
        src1 = '0;
        src2 = '0;
        imm = '0;
        pc = '0;
        rd = '0;
        out_credit = 1'b0;
        icnt = int'(exu_pkg::EXU_SLOTS);
        out_cnt = int'(exu_pkg::OUT_CREDITS);
        build_table();
        limit = 20 * tbl.size() + 100;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        while (chk < tbl.size() || icnt != int'(exu_pkg::EXU_SLOTS)
               || out_cnt != int'(exu_pkg::OUT_CREDITS)) begin
            @(posedge clk);
            #2;
        end
        if (!stalled) begin
            $display("output credits never ran out, stall window not exercised");
            abort_run();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk
);
    localparam real HALF_PERIOD = 4.0;   // 8 ns clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

/* hdl/exu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       issue_valid,
    input  wire rv_isa_pkg::opcode_t  op,
    input  wire rv_isa_pkg::funct3_t  funct3,
    input  wire                       alt,
    input  wire rv_isa_pkg::xlen_t    src1,
    input  wire rv_isa_pkg::xlen_t    src2,
    input  wire rv_isa_pkg::xlen_t    imm,
    input  wire rv_isa_pkg::xlen_t    pc,
    input  wire rv_isa_pkg::reg_idx_t rd,
    output logic                      in_credit,
    output logic                      res_valid,
    output rv_isa_pkg::reg_idx_t      res_rd,
    output logic                      res_wen,
    output rv_isa_pkg::xlen_t         res_data,
    output logic                      redirect_valid,
    output rv_isa_pkg::xlen_t         redirect_pc,
    input  wire                       out_credit
);
    exu_pkg::alu_op_e     alu_op;
    exu_pkg::res_sel_e    res_sel_s1, sel_s2;
    rv_isa_pkg::xlen_t    alu_a, alu_b, alu_y, target, load_data;
    rv_isa_pkg::xlen_t    val_s1, sdata_s1, tgt_s1, val_s2;
    rv_isa_pkg::funct3_t  f3_s1;
    rv_isa_pkg::reg_idx_t rd_s1;
    logic use_pc, use_imm, wen_s1, jump_s1, jump_s2, mem_en, mem_wen;
    logic s1_en, s2_en, s1_valid, s2_valid, take, zero, is_branch, is_jalr, is_lui;

    assign is_branch = op == rv_isa_pkg::OPC_BRANCH;
    assign is_jalr   = op == rv_isa_pkg::OPC_JALR;
    assign is_lui    = op == rv_isa_pkg::OPC_LUI;

    assign alu_a = use_pc ? pc : (is_lui ? '0 : src1);
    assign alu_b = use_imm ? imm : (use_pc ? 32'd4 : src2);   // pc without imm is the link

    exu_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .op(op), .funct3(funct3),
        .alt(alt), .out_credit(out_credit), .take(take), .res_fire(res_valid),
        .alu_op(alu_op), .use_pc(use_pc), .use_imm(use_imm), .res_sel_s1(res_sel_s1),
        .wen_s1(wen_s1), .mem_en(mem_en), .mem_wen(mem_wen), .jump_s1(jump_s1),
        .s1_en(s1_en), .s2_en(s2_en), .s1_valid(s1_valid), .s2_valid(s2_valid)
    );

    alu u_alu (.a(alu_a), .b(alu_b), .alu_op(alu_op), .result(alu_y), .zero(zero));

    branch_unit u_br (
        .funct3(funct3), .is_branch(is_branch), .is_jalr(is_jalr), .src1(src1),
        .src2(src2), .pc(pc), .imm(imm), .take(take), .target(target)
    );

    lsu u_lsu (
        .clk(clk), .rst_n(rst_n), .mem_en(mem_en), .mem_wen(mem_wen), .funct3(f3_s1),
        .addr(val_s1), .wdata(sdata_s1), .load_data(load_data)
    );

    always_ff @(posedge clk) begin
        if (s1_en) begin
            val_s1   <= alu_y;
            sdata_s1 <= src2;
            f3_s1    <= funct3;
            rd_s1    <= rd;
            tgt_s1   <= target;
        end
        if (s2_en) begin
            val_s2      <= val_s1;
            sel_s2      <= res_sel_s1;
            res_rd      <= rd_s1;
            res_wen     <= wen_s1;
            jump_s2     <= jump_s1;
            redirect_pc <= tgt_s1;
        end
    end

    assign res_valid      = s2_valid && s2_en;   // s2_en high only with a credit
    assign in_credit      = res_valid;
    assign redirect_valid = s2_valid && jump_s2;
    assign res_data       = (sel_s2 == exu_pkg::RES_LOAD) ? load_data : val_s2;

    // compare in branch_unit agrees with the ALU subtract
    a_beq_zero: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid && is_branch && funct3 == rv_isa_pkg::F3_BEQ |-> take == zero)
        else $error("beq compare disagrees with alu");

endmodule

`default_nettype wire

/* hdl/exu_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module exu_ctrl (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  issue_valid,
    input  wire rv_isa_pkg::opcode_t op,
    input  wire rv_isa_pkg::funct3_t funct3,
    input  wire                  alt,
    input  wire                  out_credit,
    input  wire                  take,
    input  wire                  res_fire,
    output exu_pkg::alu_op_e     alu_op,
    output logic                 use_pc,
    output logic                 use_imm,
    output exu_pkg::res_sel_e    res_sel_s1,
    output logic                 wen_s1,
    output logic                 mem_en,
    output logic                 mem_wen,
    output logic                 jump_s1,
    output logic                 s1_en,
    output logic                 s2_en,
    output logic                 s1_valid,
    output logic                 s2_valid
);
    exu_pkg::res_sel_e res_sel;
    exu_pkg::credit_t  credits;
    logic wen, jump, is_mem, is_store;
    logic mem_s1, store_s1;

    function automatic exu_pkg::alu_op_e arith_op(input rv_isa_pkg::funct3_t f3,
                                                  input logic sub, input logic sra);
        exu_pkg::alu_op_e r;
        case (f3)
            rv_isa_pkg::F3_ADD:  r = sub ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:  r = exu_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:  r = exu_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU: r = exu_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:  r = exu_pkg::ALU_XOR;
            rv_isa_pkg::F3_SR:   r = sra ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:   r = exu_pkg::ALU_OR;
            default:             r = exu_pkg::ALU_AND;
        endcase
        return r;
    endfunction

    always_comb begin
        alu_op   = exu_pkg::ALU_ADD;
        use_pc   = 1'b0;
        use_imm  = 1'b0;
        res_sel  = exu_pkg::RES_ALU;
        wen      = 1'b1;
        jump     = 1'b0;
        is_mem   = 1'b0;
        is_store = 1'b0;
        case (op)
            rv_isa_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                alu_op  = arith_op(funct3, 1'b0, alt);   // no subi
            end
            rv_isa_pkg::OPC_OP:    alu_op = arith_op(funct3, alt, alt);
            rv_isa_pkg::OPC_LUI:   use_imm = 1'b1;       // a forced to zero in top
            rv_isa_pkg::OPC_AUIPC: begin
                use_pc  = 1'b1;
                use_imm = 1'b1;
            end
            rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
                use_pc  = 1'b1;   // pc + 4 link
                res_sel = exu_pkg::RES_LINK;
                jump    = 1'b1;
            end
            rv_isa_pkg::OPC_BRANCH: begin
                alu_op = exu_pkg::ALU_SUB;
                wen    = 1'b0;
                jump   = take;
            end
            rv_isa_pkg::OPC_LOAD: begin
                use_imm = 1'b1;
                res_sel = exu_pkg::RES_LOAD;
                is_mem  = 1'b1;
            end
            rv_isa_pkg::OPC_STORE: begin
                use_imm  = 1'b1;
                wen      = 1'b0;
                is_mem   = 1'b1;
                is_store = 1'b1;
            end
            default: wen = 1'b0;   // retired without effect
        endcase
    end

    assign s2_en   = !s2_valid || credits != '0;
    assign s1_en   = !s1_valid || s2_en;
    assign mem_en  = s1_valid && mem_s1 && s2_en;   // memory acts on the s1 -> s2 move
    assign mem_wen = mem_en && store_s1;

    always_ff @(posedge clk) begin
        if (s1_en) begin
            res_sel_s1 <= res_sel;
            wen_s1     <= wen;
            jump_s1    <= jump;
            mem_s1     <= is_mem;
            store_s1   <= is_store;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            credits  <= exu_pkg::OUT_CREDITS;
        end else begin
            if (s1_en)
                s1_valid <= issue_valid;
            if (s2_en)
                s2_valid <= s1_valid;
            credits <= credits - exu_pkg::credit_t'(res_fire) + exu_pkg::credit_t'(out_credit);
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= exu_pkg::OUT_CREDITS)
        else $error("output credits overflow");
    a_fire_credit: assert property (@(posedge clk) disable iff (!rst_n)
        res_fire |-> credits != '0)
        else $error("result sent without credit");
    a_issue_held: assert property (@(posedge clk) disable iff (!rst_n)
        !(issue_valid && s1_valid && !s1_en))
        else $error("issue while stage 1 held");

endmodule

`default_nettype wire

/* hdl/lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      mem_en,
    input  wire                      mem_wen,
    input  wire rv_isa_pkg::funct3_t funct3,
    input  wire rv_isa_pkg::xlen_t   addr,
    input  wire rv_isa_pkg::xlen_t   wdata,
    output rv_isa_pkg::xlen_t        load_data
);
    rv_isa_pkg::xlen_t   mem [exu_pkg::DMEM_WORDS];
    rv_isa_pkg::xlen_t   rdata, wdata_sh, rdata_sh;
    rv_isa_pkg::funct3_t f3_q;
    exu_pkg::dmem_addr_t idx;
    logic [1:0] off, off_q;
    logic [3:0] mask;

    assign idx      = addr[7:2];
    assign off      = addr[1:0];
    assign wdata_sh = wdata << {off, 3'b000};   // into byte lane

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_SB: mask = 4'b0001 << off;
            rv_isa_pkg::F3_SH: mask = 4'b0011 << off;
            rv_isa_pkg::F3_SW: mask = 4'b1111;
            default:           mask = 4'b0000;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_wen) begin
                for (int i = 0; i < 4; i++)
                    if (mask[i])
                        mem[idx][8*i +: 8] <= wdata_sh[8*i +: 8];
            end else begin
                rdata <= mem[idx];
            end
            f3_q  <= funct3;
            off_q <= off;
        end
    end

    assign rdata_sh = rdata >> {off_q, 3'b000};

    always_comb begin
        case (f3_q)
            rv_isa_pkg::F3_LB:  load_data = {{24{rdata_sh[7]}}, rdata_sh[7:0]};
            rv_isa_pkg::F3_LH:  load_data = {{16{rdata_sh[15]}}, rdata_sh[15:0]};
            rv_isa_pkg::F3_LBU: load_data = {24'b0, rdata_sh[7:0]};
            rv_isa_pkg::F3_LHU: load_data = {16'b0, rdata_sh[15:0]};
            rv_isa_pkg::F3_LW:  load_data = rdata;
            default:            load_data = rdata;
        endcase
    end

    a_half_align: assert property (@(posedge clk) disable iff (!rst_n)
        mem_en && funct3[1:0] == 2'b01 |-> addr[0] == 1'b0)
        else $error("misaligned halfword access");

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  wire rv_isa_pkg::funct3_t funct3,
    input  wire                      is_branch,
    input  wire                      is_jalr,
    input  wire rv_isa_pkg::xlen_t   src1,
    input  wire rv_isa_pkg::xlen_t   src2,
    input  wire rv_isa_pkg::xlen_t   pc,
    input  wire rv_isa_pkg::xlen_t   imm,
    output logic                     take,
    output rv_isa_pkg::xlen_t        target
);
    rv_isa_pkg::xlen_t base, sum;
    logic cond;

    always_comb begin
        case (funct3)
            rv_isa_pkg::F3_BEQ:  cond = src1 == src2;
            rv_isa_pkg::F3_BNE:  cond = src1 != src2;
            rv_isa_pkg::F3_BLT:  cond = $signed(src1) < $signed(src2);
            rv_isa_pkg::F3_BGE:  cond = $signed(src1) >= $signed(src2);
            rv_isa_pkg::F3_BLTU: cond = src1 < src2;
            rv_isa_pkg::F3_BGEU: cond = src1 >= src2;
            default:             cond = 1'b0;
        endcase
    end

    assign take   = is_branch ? cond : 1'b1;   // jumps always; other ops masked by ctrl
    assign base   = is_jalr ? src1 : pc;
    assign sum    = base + imm;
    assign target = {sum[31:1], sum[0] & ~is_jalr};

endmodule

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire rv_isa_pkg::xlen_t a,
    input  wire rv_isa_pkg::xlen_t b,
    input  wire exu_pkg::alu_op_e  alu_op,
    output rv_isa_pkg::xlen_t      result,
    output logic                   zero
);
    rv_isa_pkg::xlen_t b_eff;
    logic [32:0] sum;
    logic sub, lt_s, lt_u;

    // one adder for add, sub and both compares
    assign sub   = alu_op inside {exu_pkg::ALU_SUB, exu_pkg::ALU_SLT, exu_pkg::ALU_SLTU};
    assign b_eff = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'b0, sub};

    assign lt_u = ~sum[32];   // borrow
    assign lt_s = (a[31] ^ b[31]) ? a[31] : sum[31];

    always_comb begin
        case (alu_op)
            exu_pkg::ALU_XOR:  result = a ^ b;
            exu_pkg::ALU_OR:   result = a | b;
            exu_pkg::ALU_AND:  result = a & b;
            exu_pkg::ALU_SLL:  result = a << b[4:0];
            exu_pkg::ALU_SRL:  result = a >> b[4:0];
            exu_pkg::ALU_SRA:  result = rv_isa_pkg::xlen_t'($signed(a) >>> b[4:0]);
            exu_pkg::ALU_SLT:  result = {31'b0, lt_s};
            exu_pkg::ALU_SLTU: result = {31'b0, lt_u};
            default:           result = sum[31:0];   // add, sub
        endcase
    end

    assign zero = result == '0;

endmodule

`default_nettype wire

/* hdl/exu_pkg.sv */
`default_nettype none

package exu_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // write-back source
    typedef enum logic [1:0] {
        RES_ALU,
        RES_LOAD,
        RES_LINK
    } res_sel_e;

    typedef logic [2:0] credit_t;

    localparam credit_t EXU_SLOTS   = 3'd2;   // issuer credits after reset
    localparam credit_t OUT_CREDITS = 3'd4;   // write-back buffer slots

    localparam int DMEM_WORDS = 64;
    typedef logic [5:0] dmem_addr_t;

endpackage

`default_nettype wire

/* hdl/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] xlen_t;   // data, address and immediate
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    localparam funct3_t F3_ADD  = 3'b000;   // add, sub, addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;   // srl or sra by bit 30
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    localparam funct3_t F3_SB = 3'b000;
    localparam funct3_t F3_SH = 3'b001;
    localparam funct3_t F3_SW = 3'b010;

endpackage

`default_nettype wire
